// File: decode_stage.f
design/decode_pkg.sv
design/inst_decoder.sv
design/pc_sequencer.sv
design/forward_tracker.sv
design/decode_stage.sv
bench/decode_stage_chk.sv
bench/tb_decode_stage.sv

// File: Makefile
TOP = tb_decode_stage
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f decode_stage.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f decode_stage.f --top-module $(TOP) -Mdir $(OBJ)
	-./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ) sim.log

// File: bench/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    typedef struct packed {
        logic      invalid;
        pc_we_e    pc_we;
        logic      reg_we;
        wb_sel_e   wb_sel;
        wb_dst_e   wb_dst;
        alu_op_e   alu_op;
        logic      sign_ext;
        logic      load_unsigned;
        logic      mem_rd;
        logic      mem_we;
        mem_size_e mem_size;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        opa_sel_e a_sel;
        opb_sel_e b_sel;
        addr_t    next_pc;
        logic     wr;
        reg_idx_t dreg;
    } ref_t;

    localparam logic [5:0] OPS [27] = '{OP_SPECIAL, OP_SPECIAL, OP_SPECIAL, OP_SPECIAL,
        OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH,
        OP_SW, 6'b010_000, 6'b000_111};   // last two are unused codes
    localparam logic [5:0] FNS [19] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
        FN_JR, FN_JALR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
        FN_SLT, FN_SLTU, 6'b001_100};

    logic  clk = 1'b0;
    logic  rst_i, inst_valid_i, data_valid_i, flush_i;
    inst_t inst_data_i;
    addr_t flush_pc_i, inst_addr_o, pc_o;
    logic  invalid_o, reg_we_o, sign_ext_o, load_unsigned_o, mem_rd_o, mem_we_o;
    reg_idx_t  rs_o, rt_o, rd_o, shamt_o;
    imm_t      imm_o;
    pc_we_e    pc_we_o;
    wb_sel_e   wb_sel_o;
    wb_dst_e   wb_dst_o;
    alu_op_e   alu_op_o;
    opa_sel_e  alu_a_sel_o;
    opb_sel_e  alu_b_sel_o;
    mem_size_e mem_size_o;

    logic [15:0] lfsr = 16'd7418;
    int          cyc = 0;
    realtime     edge_t = 0.0;
    int          err_count = 0;

    // model state
    logic     m_ready = 1'b0;
    logic     m_clear;
    ref_t     m_exp;
    inst_t    m_word;
    addr_t    m_pc;
    logic     ex_v, mem_v;
    reg_idx_t ex_r, mem_r;

    decode_stage u_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc    <= cyc + 1;
        edge_t <= $realtime;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic ref_t ref_decode(input inst_t w, input addr_t pc, input logic xv,
                                        input reg_idx_t xr, input logic mv, input reg_idx_t mr);
        ref_t     r;
        logic [5:0] op;
        logic [5:0] fn;
        src_use_e a_use;
        logic     b_rt;
        opa_sel_e a_fix;
        opb_sel_e b_fix;
        reg_idx_t a_reg;
        op = w[31:26];
        fn = w[5:0];
        r = '{ctrl: '{invalid: 1'b0, pc_we: PC_WE_NONE, reg_we: 1'b0, wb_sel: WB_ALU,
                      wb_dst: DST_RD, alu_op: ALU_ADD, sign_ext: 1'b0, load_unsigned: 1'b0,
                      mem_rd: 1'b0, mem_we: 1'b0, mem_size: SZ_WORD},
              a_sel: A_ZERO, b_sel: B_ZERO, next_pc: pc + 32'd4, wr: 1'b0, dreg: w[15:11]};
        a_use = USE_NONE;
        b_rt  = 1'b0;
        a_fix = A_ZERO;
        b_fix = B_ZERO;
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_SLT, FN_SLTU: begin
                        a_use = USE_RS;
                        b_rt  = 1'b1;
                        r.ctrl.reg_we = 1'b1;
                        case (fn)
                            FN_SUB, FN_SUBU: r.ctrl.alu_op = ALU_SUB;
                            FN_AND: r.ctrl.alu_op = ALU_AND;
                            FN_OR:  r.ctrl.alu_op = ALU_OR;
                            FN_XOR: r.ctrl.alu_op = ALU_XOR;
                            FN_NOR: r.ctrl.alu_op = ALU_NOR;
                            FN_SLT: r.ctrl.alu_op = ALU_SLT;
                            FN_SLTU: r.ctrl.alu_op = ALU_SLTU;
                            default: r.ctrl.alu_op = ALU_ADD;
                        endcase
                    end
                    FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
                        a_use = USE_RT;
                        b_fix = (fn[2]) ? B_ZERO : B_SHAMT;   // variable shifts have bit 2 set
                        r.ctrl.reg_we = 1'b1;
                        r.ctrl.alu_op = (fn[1:0] == 2'b00) ? ALU_SLL :
                                        ((fn[1:0] == 2'b10) ? ALU_SRL : ALU_SRA);
                    end
                    FN_JR, FN_JALR: begin
                        a_use = USE_RS;
                        r.ctrl.pc_we = PC_WE_ALWAYS;
                        r.next_pc    = pc;
                        if (fn == FN_JALR) begin
                            r.ctrl.reg_we = 1'b1;
                            r.ctrl.wb_sel = WB_LINK;
                        end
                    end
                    default: r.ctrl.invalid = 1'b1;
                endcase
            end
            OP_J, OP_JAL: begin
                r.next_pc = {pc[31:28], w[25:0], 2'b00};
                if (op == OP_JAL) begin
                    r.ctrl.reg_we = 1'b1;
                    r.ctrl.wb_sel = WB_LINK;
                    r.ctrl.wb_dst = DST_RA;
                    r.dreg        = 5'd31;
                end
            end
            OP_BEQ, OP_BNE, OP_REGIMM: begin
                if (op == OP_REGIMM && w[20:17] != 4'd0) begin
                    r.ctrl.invalid = 1'b1;
                end else begin
                    a_use = USE_RS;
                    b_rt  = (op != OP_REGIMM);
                    r.ctrl.pc_we  = PC_WE_COND;
                    r.ctrl.alu_op = (op == OP_BEQ) ? ALU_EQ : ((op == OP_BNE) ? ALU_NE : ALU_SLT);
                    r.next_pc = pc + 32'd4 + {{14{w[15]}}, w[15:0], 2'b00};
                end
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                r.ctrl.reg_we = 1'b1;
                r.ctrl.wb_dst = DST_RT;
                r.dreg        = w[20:16];
                r.ctrl.sign_ext = (op <= OP_SLTIU);
                case (op)
                    OP_SLTI:  r.ctrl.alu_op = ALU_SLT;
                    OP_SLTIU: r.ctrl.alu_op = ALU_SLTU;
                    OP_ANDI:  r.ctrl.alu_op = ALU_AND;
                    OP_ORI:   r.ctrl.alu_op = ALU_OR;
                    OP_XORI:  r.ctrl.alu_op = ALU_XOR;
                    OP_LUI:   r.ctrl.alu_op = ALU_LUI;
                    default:  r.ctrl.alu_op = ALU_ADD;
                endcase
                if (op == OP_LUI) begin
                    a_fix = A_IMM;
                end else begin
                    a_use = USE_RT;
                    b_fix = B_IMM;
                end
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: begin
                a_use = USE_RT;
                b_fix = B_IMM;
                r.ctrl.sign_ext = 1'b1;
                r.ctrl.mem_size = (op[1:0] == 2'b00) ? SZ_BYTE :
                                  ((op[1:0] == 2'b01) ? SZ_HALF : SZ_WORD);
                if (op[3]) begin
                    r.ctrl.mem_we = 1'b1;
                end else begin
                    r.ctrl.mem_rd = 1'b1;
                    r.ctrl.reg_we = 1'b1;
                    r.ctrl.wb_sel = WB_MEM;
                    r.ctrl.wb_dst = DST_RT;
                    r.dreg        = w[20:16];
                    r.ctrl.load_unsigned = op[2];
                end
            end
            default: r.ctrl.invalid = 1'b1;
        endcase
        r.wr  = r.ctrl.reg_we;
        a_reg = (a_use == USE_RT) ? w[20:16] : w[25:21];
        if (a_use == USE_NONE) r.a_sel = a_fix;
        else if (xv && xr == a_reg) r.a_sel = A_EXEC;   // youngest writer first
        else if (mv && mr == a_reg) r.a_sel = A_MEM;
        else r.a_sel = (a_use == USE_RS) ? A_RS : A_RT;
        if (!b_rt) r.b_sel = b_fix;
        else if (xv && xr == w[20:16]) r.b_sel = B_EXEC;
        else if (mv && mr == w[20:16]) r.b_sel = B_MEM;
        else r.b_sel = B_RT;
        return r;
    endfunction

    task automatic fail_check(input string msg);
        err_count++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "decode stage mismatch");
    endtask

    task automatic check_ctrl(input ctrl_t act, input ctrl_t exp);
        if (act !== exp) fail_check($sformatf("control got %h expected %h", act, exp));
    endtask

    task automatic check_addr(input addr_t act, input addr_t exp, input string what);
        if (act !== exp) fail_check($sformatf("%s got %h expected %h", what, act, exp));
    endtask

    task automatic check_sel(input opa_sel_e a, input opa_sel_e ea, input opb_sel_e b,
                             input opb_sel_e eb);
        if (a !== ea || b !== eb)
            fail_check($sformatf("selects got %0d/%0d expected %0d/%0d", a, b, ea, eb));
    endtask

    task automatic check_field(input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
                               input reg_idx_t sh, input imm_t imm, input inst_t w);
        if (rs !== w[25:21] || rt !== w[20:16] || rd !== w[15:11] || sh !== w[10:6]
            || imm !== w[15:0])
            fail_check($sformatf("register fields do not match word %h", w));
    endtask

    // model follows the stage on every edge
    always @(posedge clk) begin
        if (rst_i || flush_i) begin
            m_ready = 1'b1;
            m_clear = 1'b1;
            m_word  = '0;
            m_pc    = rst_i ? '0 : flush_pc_i;
            ex_v    = 1'b0;
            mem_v   = 1'b0;
        end else if (data_valid_i && m_ready) begin
            m_clear = 1'b0;
            m_word  = inst_valid_i ? inst_data_i : '0;
            m_exp   = ref_decode(m_word, m_pc, ex_v, ex_r, mem_v, mem_r);
            m_pc    = m_exp.next_pc;
            mem_v   = ex_v;
            mem_r   = ex_r;
            ex_v    = m_exp.wr;
            ex_r    = m_exp.dreg;
        end
    end

    always @(negedge clk) begin
        ctrl_t act;
        ctrl_t exp;
        if (m_ready) begin
            act = '{invalid_o, pc_we_o, reg_we_o, wb_sel_o, wb_dst_o, alu_op_o, sign_ext_o,
                    load_unsigned_o, mem_rd_o, mem_we_o, mem_size_o};
            check_addr(pc_o, m_pc, "pc_o");
            check_addr(inst_addr_o, m_pc, "inst_addr_o");
            check_field(rs_o, rt_o, rd_o, shamt_o, imm_o, m_word);
            if (m_clear) begin
                exp = act;   // only enables and pc_we are defined after a clear
                exp.invalid = 1'b0;
                exp.pc_we   = PC_WE_ALWAYS;
                exp.reg_we  = 1'b0;
                exp.mem_rd  = 1'b0;
                exp.mem_we  = 1'b0;
                check_ctrl(act, exp);
            end else begin
                check_ctrl(act, m_exp.ctrl);
                check_sel(alu_a_sel_o, m_exp.a_sel, alu_b_sel_o, m_exp.b_sel);
            end
        end
    end

    // returns 1 ns after the next rising edge
    task automatic wait_next_edge();
        int start;
        int waited;
        start  = cyc;
        waited = 0;
        while (!(cyc != start && $realtime >= edge_t + 1.0) && waited < 40) begin
            #0.5;
            waited++;
        end
        if (waited >= 40) begin
            $display("clock stopped, no rising edge within 20 ns");
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    endtask

    task automatic make_word(output inst_t w);
        logic [31:0] v;
        logic [5:0]  op;
        reg_idx_t    rg [3];
        take_bits(5, v);
        op = OPS[v % 27];
        for (int i = 0; i < 3; i++) begin
            take_bits(3, v);
            rg[i] = (v[2:0] == 3'd7) ? 5'd31 : {2'b00, v[2:0]};   // small set gives hazards
        end
        if (op == OP_SPECIAL) begin
            take_bits(5, v);
            w[5:0] = FNS[v % 19];
            take_bits(5, v);
            w = {op, rg[0], rg[1], rg[2], v[4:0], w[5:0]};
        end else if (op == OP_J || op == OP_JAL) begin
            take_bits(26, v);
            w = {op, v[25:0]};
        end else begin
            take_bits(16, v);
            if (op == OP_REGIMM) rg[1] = {3'b000, rg[1][1:0]};
            w = {op, rg[0], rg[1], v[15:0]};
        end
    endtask

    initial begin
        logic [31:0] v;
        inst_t       w;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        data_valid_i = 1'b0;
        flush_i      = 1'b0;
        flush_pc_i   = '0;
        inst_data_i  = '0;
        repeat (3) wait_next_edge();
        rst_i = 1'b0;
        for (int n = 0; n < 600; n++) begin
            make_word(w);
            inst_data_i = w;
            take_bits(4, v);
            inst_valid_i = (v[3:0] != 4'd0);
            take_bits(3, v);
            data_valid_i = (v[2:0] != 3'd0);
            take_bits(5, v);
            flush_i = (v[4:0] == 5'd0);
            take_bits(30, v);
            flush_pc_i = {v[29:0], 2'b00};
            wait_next_edge();
        end
        data_valid_i = 1'b0;
        flush_i      = 1'b0;
        repeat (2) wait_next_edge();
        if (err_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "errors found");
        end
    end

endmodule

// File: bench/decode_stage_chk.sv
`timescale 1ns/1ps

module decode_stage_chk (
    input logic                  clk,
    input logic                  rst_i,
    input logic                  flush_i,
    input logic                  data_valid_i,
    input decode_pkg::addr_t     pc_o,
    input logic                  invalid_o,
    input logic                  reg_we_o,
    input logic                  mem_rd_o,
    input logic                  mem_we_o,
    input decode_pkg::alu_op_e   alu_op_o,
    input decode_pkg::opa_sel_e  alu_a_sel_o,
    input decode_pkg::opb_sel_e  alu_b_sel_o,
    input decode_pkg::imm_t      imm_o
);

    a_mem_excl: assert property (@(posedge clk) disable iff (rst_i) !(mem_rd_o && mem_we_o))
        else $error("memory read and write both high");

    a_invalid_no_wb: assert property (@(posedge clk) disable iff (rst_i) invalid_o |-> !reg_we_o)
        else $error("invalid instruction writes a register");

    a_reset_pc: assert property (@(posedge clk) rst_i |=> (pc_o == '0))
        else $error("pc not zero after reset");

    // a stalled stage keeps every output
    a_stall_hold: assert property (@(posedge clk) (!data_valid_i && !rst_i && !flush_i)
        |=> $stable({pc_o, invalid_o, reg_we_o, mem_rd_o, mem_we_o, alu_op_o, alu_a_sel_o,
                     alu_b_sel_o, imm_o}))
        else $error("outputs changed while stalled");

endmodule

bind decode_stage decode_stage_chk u_chk (.*);

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  decode_pkg::inst_t     inst_data_i,
    input  logic                  inst_valid_i,
    input  logic                  data_valid_i,
    input  logic                  flush_i,
    input  decode_pkg::addr_t     flush_pc_i,
    output decode_pkg::addr_t     inst_addr_o,
    output decode_pkg::addr_t     pc_o,
    output logic                  invalid_o,
    output decode_pkg::reg_idx_t  rs_o,
    output decode_pkg::reg_idx_t  rt_o,
    output decode_pkg::reg_idx_t  rd_o,
    output decode_pkg::reg_idx_t  shamt_o,
    output decode_pkg::imm_t      imm_o,
    output decode_pkg::pc_we_e    pc_we_o,
    output logic                  reg_we_o,
    output decode_pkg::wb_sel_e   wb_sel_o,
    output decode_pkg::wb_dst_e   wb_dst_o,
    output decode_pkg::alu_op_e   alu_op_o,
    output decode_pkg::opa_sel_e  alu_a_sel_o,
    output decode_pkg::opb_sel_e  alu_b_sel_o,
    output logic                  sign_ext_o,
    output logic                  load_unsigned_o,
    output logic                  mem_rd_o,
    output logic                  mem_we_o,
    output decode_pkg::mem_size_e mem_size_o
);
    import decode_pkg::*;

    inst_t     dec_inst;
    inst_t     word_q;
    logic      dec_valid;
    logic      dec_is_jump;
    logic      dec_is_branch;
    logic      dec_is_jreg;
    pc_we_e    dec_pc_we;
    logic      dec_reg_we;
    wb_sel_e   dec_wb_sel;
    wb_dst_e   dec_wb_dst;
    reg_idx_t  dec_dst_reg;
    alu_op_e   dec_alu_op;
    src_use_e  dec_a_use;
    logic      dec_b_use_rt;
    opb_sel_e  dec_b_fixed;
    opa_sel_e  dec_a_fixed;
    logic      dec_sign_ext;
    logic      dec_load_unsigned;
    logic      dec_mem_rd;
    logic      dec_mem_we;
    mem_size_e dec_mem_size;
    opa_sel_e  fwd_a_sel;
    opb_sel_e  fwd_b_sel;

    assign dec_inst = inst_valid_i ? inst_data_i : NOP_WORD;   // empty fetch becomes a nop

    inst_decoder u_decoder (
        .inst_i          (dec_inst),
        .valid_o         (dec_valid),
        .is_jump_o       (dec_is_jump),
        .is_branch_o     (dec_is_branch),
        .is_jreg_o       (dec_is_jreg),
        .pc_we_o         (dec_pc_we),
        .reg_we_o        (dec_reg_we),
        .wb_sel_o        (dec_wb_sel),
        .wb_dst_o        (dec_wb_dst),
        .dst_reg_o       (dec_dst_reg),
        .alu_op_o        (dec_alu_op),
        .a_use_o         (dec_a_use),
        .b_use_rt_o      (dec_b_use_rt),
        .b_fixed_o       (dec_b_fixed),
        .a_fixed_o       (dec_a_fixed),
        .sign_ext_o      (dec_sign_ext),
        .load_unsigned_o (dec_load_unsigned),
        .mem_rd_o        (dec_mem_rd),
        .mem_we_o        (dec_mem_we),
        .mem_size_o      (dec_mem_size)
    );

    pc_sequencer u_pc (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .flush_pc_i  (flush_pc_i),
        .advance_i   (data_valid_i),
        .inst_i      (dec_inst),
        .is_jump_i   (dec_is_jump),
        .is_branch_i (dec_is_branch),
        .is_jreg_i   (dec_is_jreg),
        .pc_o        (pc_o)
    );

    forward_tracker u_fwd (
        .clk        (clk),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .advance_i  (data_valid_i),
        .inst_i     (dec_inst),
        .a_use_i    (dec_a_use),
        .b_use_rt_i (dec_b_use_rt),
        .a_fixed_i  (dec_a_fixed),
        .b_fixed_i  (dec_b_fixed),
        .reg_we_i   (dec_reg_we),
        .dst_reg_i  (dec_dst_reg),
        .a_sel_o    (fwd_a_sel),
        .b_sel_o    (fwd_b_sel)
    );

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            word_q          <= NOP_WORD;
            invalid_o       <= 1'b0;
            pc_we_o         <= PC_WE_ALWAYS;
            reg_we_o        <= 1'b0;
            wb_sel_o        <= WB_ALU;
            wb_dst_o        <= DST_RD;
            alu_op_o        <= ALU_ADD;
            alu_a_sel_o     <= A_RS;
            alu_b_sel_o     <= B_RT;
            sign_ext_o      <= 1'b0;
            load_unsigned_o <= 1'b0;
            mem_rd_o        <= 1'b0;
            mem_we_o        <= 1'b0;
            mem_size_o      <= SZ_BYTE;
        end else if (data_valid_i) begin
            word_q          <= dec_inst;
            invalid_o       <= !dec_valid;
            pc_we_o         <= dec_pc_we;
            reg_we_o        <= dec_reg_we;
            wb_sel_o        <= dec_wb_sel;
            wb_dst_o        <= dec_wb_dst;
            alu_op_o        <= dec_alu_op;
            alu_a_sel_o     <= fwd_a_sel;   // selects see the history before this shift
            alu_b_sel_o     <= fwd_b_sel;
            sign_ext_o      <= dec_sign_ext;
            load_unsigned_o <= dec_load_unsigned;
            mem_rd_o        <= dec_mem_rd;
            mem_we_o        <= dec_mem_we;
            mem_size_o      <= dec_mem_size;
        end
    end

    assign rs_o        = word_q[25:21];
    assign rt_o        = word_q[20:16];
    assign rd_o        = word_q[15:11];
    assign shamt_o     = word_q[10:6];
    assign imm_o       = word_q[15:0];
    assign inst_addr_o = pc_o;

endmodule

// File: design/forward_tracker.sv
`timescale 1ns/1ps

module forward_tracker (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 flush_i,
    input  logic                 advance_i,
    input  decode_pkg::inst_t    inst_i,
    input  decode_pkg::src_use_e a_use_i,
    input  logic                 b_use_rt_i,
    input  decode_pkg::opa_sel_e a_fixed_i,
    input  decode_pkg::opb_sel_e b_fixed_i,
    input  logic                 reg_we_i,
    input  decode_pkg::reg_idx_t dst_reg_i,
    output decode_pkg::opa_sel_e a_sel_o,
    output decode_pkg::opb_sel_e b_sel_o
);
    import decode_pkg::*;

    logic     exec_vld_q;
    logic     mem_vld_q;
    reg_idx_t exec_reg_q;
    reg_idx_t mem_reg_q;
    reg_idx_t a_reg;
    reg_idx_t b_reg;

    // r0 gets no special case here
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            exec_vld_q <= 1'b0;
            mem_vld_q  <= 1'b0;
        end else if (advance_i) begin
            exec_vld_q <= reg_we_i;
            mem_vld_q  <= exec_vld_q;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            exec_reg_q <= dst_reg_i;
            mem_reg_q  <= exec_reg_q;
        end
    end

    assign a_reg = (a_use_i == USE_RT) ? inst_i[20:16] : inst_i[25:21];
    assign b_reg = inst_i[20:16];

    always_comb begin
        if (a_use_i == USE_NONE) a_sel_o = a_fixed_i;
        else if (exec_vld_q && (exec_reg_q == a_reg)) a_sel_o = A_EXEC;   // youngest wins
        else if (mem_vld_q && (mem_reg_q == a_reg)) a_sel_o = A_MEM;
        else a_sel_o = (a_use_i == USE_RS) ? A_RS : A_RT;

        if (!b_use_rt_i) b_sel_o = b_fixed_i;
        else if (exec_vld_q && (exec_reg_q == b_reg)) b_sel_o = B_EXEC;
        else if (mem_vld_q && (mem_reg_q == b_reg)) b_sel_o = B_MEM;
        else b_sel_o = B_RT;
    end

endmodule

// File: design/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              flush_i,
    input  decode_pkg::addr_t flush_pc_i,
    input  logic              advance_i,
    input  decode_pkg::inst_t inst_i,
    input  logic              is_jump_i,
    input  logic              is_branch_i,
    input  logic              is_jreg_i,
    output decode_pkg::addr_t pc_o
);
    import decode_pkg::*;

    addr_t pc_q;
    addr_t seq_addr;
    addr_t jump_addr;
    addr_t branch_addr;
    addr_t next_pc;

    assign seq_addr    = pc_q + PC_STEP;
    assign jump_addr   = {pc_q[31:28], inst_i[25:0], 2'b00};   // 256 MB region of pc
    assign branch_addr = seq_addr + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

    always_comb begin
        if (is_jump_i) next_pc = jump_addr;
        else if (is_branch_i) next_pc = branch_addr;
        else if (is_jreg_i) next_pc = pc_q;   // execute redirects from rs
        else next_pc = seq_addr;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= '0;
        end else if (flush_i) begin
            pc_q <= flush_pc_i;
        end else if (advance_i) begin
            pc_q <= next_pc;
        end
    end

    assign pc_o = pc_q;

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::inst_t     inst_i,
    output logic                  valid_o,
    output logic                  is_jump_o,
    output logic                  is_branch_o,
    output logic                  is_jreg_o,
    output decode_pkg::pc_we_e    pc_we_o,
    output logic                  reg_we_o,
    output decode_pkg::wb_sel_e   wb_sel_o,
    output decode_pkg::wb_dst_e   wb_dst_o,
    output decode_pkg::reg_idx_t  dst_reg_o,
    output decode_pkg::alu_op_e   alu_op_o,
    output decode_pkg::src_use_e  a_use_o,
    output logic                  b_use_rt_o,
    output decode_pkg::opb_sel_e  b_fixed_o,
    output decode_pkg::opa_sel_e  a_fixed_o,
    output logic                  sign_ext_o,
    output logic                  load_unsigned_o,
    output logic                  mem_rd_o,
    output logic                  mem_we_o,
    output decode_pkg::mem_size_e mem_size_o
);
    import decode_pkg::*;

    logic [5:0] op;
    logic [5:0] fn;
    logic       special;
    logic       is_load, is_store, is_imm_arith, is_lui;
    logic       is_reg_arith, is_fshift, is_vshift;
    logic       is_jal, is_jalr, is_beq_bne, is_regimm_br;

    assign op      = inst_i[31:26];
    assign fn      = inst_i[5:0];
    assign special = (op == OP_SPECIAL);

    assign is_load      = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    assign is_store     = op inside {OP_SB, OP_SH, OP_SW};
    assign is_imm_arith = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};
    assign is_lui       = (op == OP_LUI);
    assign is_reg_arith = special && (fn inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT,
                                                 FN_SLTU, FN_AND, FN_OR, FN_XOR, FN_NOR});
    assign is_fshift    = special && (fn inside {FN_SLL, FN_SRL, FN_SRA});
    assign is_vshift    = special && (fn inside {FN_SLLV, FN_SRLV, FN_SRAV});
    assign is_jal       = (op == OP_JAL);
    assign is_jalr      = special && (fn == FN_JALR);
    assign is_beq_bne   = op inside {OP_BEQ, OP_BNE};
    assign is_regimm_br = (op == OP_REGIMM) && (inst_i[20:16] inside {RT_BLTZ, RT_BGEZ});

    assign is_jump_o   = (op == OP_J) || is_jal;
    assign is_branch_o = is_beq_bne || is_regimm_br;
    assign is_jreg_o   = (special && (fn == FN_JR)) || is_jalr;

    assign valid_o = is_load || is_store || is_imm_arith || is_lui || is_reg_arith || is_fshift
                     || is_vshift || is_jump_o || is_branch_o || is_jreg_o;

    // unmatched words fall out of every group, so all enables stay low
    assign reg_we_o = is_load || is_imm_arith || is_lui || is_reg_arith || is_fshift || is_vshift
                      || is_jal || is_jalr;
    assign mem_rd_o = is_load;
    assign mem_we_o = is_store;

    assign sign_ext_o      = is_load || is_store || (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU});
    assign load_unsigned_o = op inside {OP_LBU, OP_LHU};

    assign b_use_rt_o = is_reg_arith || is_beq_bne;
    assign a_fixed_o  = is_lui ? A_IMM : A_ZERO;

    always_comb begin
        pc_we_o = PC_WE_NONE;
        if (is_jreg_o) pc_we_o = PC_WE_ALWAYS;   // target comes from rs
        else if (is_branch_o) pc_we_o = PC_WE_COND;
    end

    always_comb begin
        wb_sel_o  = is_load ? WB_MEM : ((is_jal || is_jalr) ? WB_LINK : WB_ALU);
        wb_dst_o  = DST_RD;
        dst_reg_o = inst_i[15:11];
        if (is_jal) begin
            wb_dst_o  = DST_RA;
            dst_reg_o = RA_REG;
        end else if (is_load || is_imm_arith || is_lui) begin
            wb_dst_o  = DST_RT;
            dst_reg_o = inst_i[20:16];
        end
    end

    always_comb begin
        a_use_o = USE_NONE;
        if (is_reg_arith || is_branch_o || is_jreg_o) a_use_o = USE_RS;
        else if (is_imm_arith || is_load || is_store || is_fshift || is_vshift) a_use_o = USE_RT;
        b_fixed_o = B_ZERO;   // lui also ends here, its value goes through a
        if (is_imm_arith || is_load || is_store) b_fixed_o = B_IMM;
        else if (is_fshift) b_fixed_o = B_SHAMT;
        mem_size_o = SZ_WORD;
        if (op inside {OP_LB, OP_LBU, OP_SB}) mem_size_o = SZ_BYTE;
        else if (op inside {OP_LH, OP_LHU, OP_SH}) mem_size_o = SZ_HALF;
    end

    always_comb begin
        alu_op_o = ALU_ADD;   // memory address and jumps add
        case (op)
            OP_SLTI:   alu_op_o = ALU_SLT;
            OP_SLTIU:  alu_op_o = ALU_SLTU;
            OP_ANDI:   alu_op_o = ALU_AND;
            OP_ORI:    alu_op_o = ALU_OR;
            OP_XORI:   alu_op_o = ALU_XOR;
            OP_LUI:    alu_op_o = ALU_LUI;
            OP_BEQ:    alu_op_o = ALU_EQ;
            OP_BNE:    alu_op_o = ALU_NE;
            OP_REGIMM: if (is_regimm_br) alu_op_o = ALU_SLT;   // sign test of rs
            OP_SPECIAL: begin
                case (fn)
                    FN_SUB, FN_SUBU: alu_op_o = ALU_SUB;
                    FN_SLT:          alu_op_o = ALU_SLT;
                    FN_SLTU:         alu_op_o = ALU_SLTU;
                    FN_AND:          alu_op_o = ALU_AND;
                    FN_OR:           alu_op_o = ALU_OR;
                    FN_XOR:          alu_op_o = ALU_XOR;
                    FN_NOR:          alu_op_o = ALU_NOR;
                    FN_SLL, FN_SLLV: alu_op_o = ALU_SLL;
                    FN_SRL, FN_SRLV: alu_op_o = ALU_SRL;
                    FN_SRA, FN_SRAV: alu_op_o = ALU_SRA;
                    default:         alu_op_o = ALU_ADD;
                endcase
            end
            default:   alu_op_o = ALU_ADD;
        endcase
    end

endmodule

// File: design/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;

    localparam inst_t    NOP_WORD = 32'h0000_0000;   // sll r0, r0, 0
    localparam reg_idx_t RA_REG   = 5'd31;           // link register
    localparam addr_t    PC_STEP  = 32'd4;

    localparam logic [5:0] OP_SPECIAL = 6'b000_000;
    localparam logic [5:0] OP_REGIMM  = 6'b000_001;
    localparam logic [5:0] OP_J       = 6'b000_010;
    localparam logic [5:0] OP_JAL     = 6'b000_011;
    localparam logic [5:0] OP_BEQ     = 6'b000_100;
    localparam logic [5:0] OP_BNE     = 6'b000_101;
    localparam logic [5:0] OP_ADDI    = 6'b001_000;
    localparam logic [5:0] OP_ADDIU   = 6'b001_001;
    localparam logic [5:0] OP_SLTI    = 6'b001_010;
    localparam logic [5:0] OP_SLTIU   = 6'b001_011;
    localparam logic [5:0] OP_ANDI    = 6'b001_100;
    localparam logic [5:0] OP_ORI     = 6'b001_101;
    localparam logic [5:0] OP_XORI    = 6'b001_110;
    localparam logic [5:0] OP_LUI     = 6'b001_111;
    localparam logic [5:0] OP_LB      = 6'b100_000;
    localparam logic [5:0] OP_LH      = 6'b100_001;
    localparam logic [5:0] OP_LW      = 6'b100_011;
    localparam logic [5:0] OP_LBU     = 6'b100_100;
    localparam logic [5:0] OP_LHU     = 6'b100_101;
    localparam logic [5:0] OP_SB      = 6'b101_000;
    localparam logic [5:0] OP_SH      = 6'b101_001;
    localparam logic [5:0] OP_SW      = 6'b101_011;

    // function field of OP_SPECIAL
    localparam logic [5:0] FN_SLL     = 6'b000_000;
    localparam logic [5:0] FN_SRL     = 6'b000_010;
    localparam logic [5:0] FN_SRA     = 6'b000_011;
    localparam logic [5:0] FN_SLLV    = 6'b000_100;
    localparam logic [5:0] FN_SRLV    = 6'b000_110;
    localparam logic [5:0] FN_SRAV    = 6'b000_111;
    localparam logic [5:0] FN_JR      = 6'b001_000;
    localparam logic [5:0] FN_JALR    = 6'b001_001;
    localparam logic [5:0] FN_ADD     = 6'b100_000;
    localparam logic [5:0] FN_ADDU    = 6'b100_001;
    localparam logic [5:0] FN_SUB     = 6'b100_010;
    localparam logic [5:0] FN_SUBU    = 6'b100_011;
    localparam logic [5:0] FN_AND     = 6'b100_100;
    localparam logic [5:0] FN_OR      = 6'b100_101;
    localparam logic [5:0] FN_XOR     = 6'b100_110;
    localparam logic [5:0] FN_NOR     = 6'b100_111;
    localparam logic [5:0] FN_SLT     = 6'b101_010;
    localparam logic [5:0] FN_SLTU    = 6'b101_011;

    localparam logic [4:0] RT_BLTZ    = 5'b00000;   // rt field of OP_REGIMM
    localparam logic [4:0] RT_BGEZ    = 5'b00001;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_SLT, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {PC_WE_ALWAYS, PC_WE_COND, PC_WE_NONE} pc_we_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;
    typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} wb_dst_e;

    // codes 4 and 5 stay free, a zero and immediate keep their old encodings
    typedef enum logic [2:0] {
        A_RS = 3'd0, A_RT = 3'd1, A_EXEC = 3'd2, A_MEM = 3'd3, A_ZERO = 3'd6, A_IMM = 3'd7
    } opa_sel_e;

    typedef enum logic [2:0] {B_RT, B_IMM, B_SHAMT, B_EXEC, B_MEM, B_ZERO} opb_sel_e;
    typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} mem_size_e;
    typedef enum logic [1:0] {USE_RS, USE_RT, USE_NONE} src_use_e;

endpackage
